// File: project.f
+incdir+logic
logic/mem_pkg.sv
logic/mem_req_if.sv
logic/store_align.sv
logic/req_delay_line.sv
logic/sram_array.sv
logic/load_extract.sv
logic/mem_subsys_top.sv
tests/tb_mem_subsys.sv

// File: Bender.yml
package:
  name: mem_subsys

export_include_dirs:
  - logic

sources:
  - logic/mem_pkg.sv
  - logic/mem_req_if.sv
  - logic/store_align.sv
  - logic/req_delay_line.sv
  - logic/sram_array.sv
  - logic/load_extract.sv
  - logic/mem_subsys_top.sv
  - target: test
    files:
      - tests/tb_mem_subsys.sv

// File: tests/tb_mem_subsys.sv
// Directed testbench for the data-memory subsystem, run as the simulation top with project.f
`timescale 1ns/10ps
`include "mem_params.svh"

module tb_mem_subsys import mem_pkg::*; ();

  localparam int DELAY      = `MEM_DELAY_CYCLES;
  localparam int WAIT_LIMIT = DELAY + 10;  // Cycles before a missing strobe counts as lost

  logic clk, rst, ld_valid, st_valid, ld_unsigned, rd_done, wt_done;
  logic [31:0] addr, st_data, ld_data;
  mem_size_e size;
  logic [15:0] lfsr_state;
  logic [7:0] ref_mem [`MEM_DEPTH_WORDS*MEM_LANES];  // Byte image of the array
  int errors = 0;
  int checks = 0;
  int tests_run = 0;
  int tests_failed = 0;

  mem_subsys_top u_dut (
    .clk (clk), .rst (rst), .ld_valid (ld_valid), .st_valid (st_valid), .addr (addr),
    .size (size), .ld_unsigned (ld_unsigned), .st_data (st_data), .ld_data (ld_data),
    .rd_done (rd_done), .wt_done (wt_done)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Fibonacci LFSR, taps 16 14 13 11, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic int size_bytes(input mem_size_e sz);
    return (sz == SIZE_BYTE) ? 1 : (sz == SIZE_HALF) ? 2 : 4;
  endfunction

  // First byte touched, low address bits below the size are ignored
  function automatic int ref_index(input logic [31:0] a, input mem_size_e sz);
    int n;
    n = size_bytes(sz);
    return int'((a / 4) % `MEM_DEPTH_WORDS) * 4 + int'(a % 4) / n * n;
  endfunction

  task automatic ref_store(input logic [31:0] a, input mem_size_e sz, input logic [31:0] d);
    int base;
    base = ref_index(a, sz);
    for (int b = 0; b < size_bytes(sz); b++) ref_mem[base + b] = d[8*b +: 8];
  endtask

  function automatic logic [31:0] ref_load(input logic [31:0] a, input mem_size_e sz,
                                           input logic uns);
    logic [31:0] val;
    int base, n;
    val = '0;
    base = ref_index(a, sz);
    n = size_bytes(sz);
    for (int b = 0; b < n; b++) val[8*b +: 8] = ref_mem[base + b];
    if (!uns && n < 4 && val[8*n-1]) val = val | ~((32'h1 << (8*n)) - 1);  // Sign fill
    return val;
  endfunction

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    assert (got === exp) else begin
      $display("ERROR @%0t: %s, got %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic finish_test(input string name, input int err0);
    tests_run++;
    if (errors == err0) $display("%s: pass", name);
    else begin
      tests_failed++;
      $display("%s: fail with %0d errors", name, errors - err0);
    end
  endtask

  // One request, then wait for its done strobe with a bound
  task automatic access(input logic ld, input logic st, input logic [31:0] a,
                        input mem_size_e sz, input logic uns, input logic [31:0] d,
                        output logic [31:0] data, output int lat,
                        output logic rd_seen, output logic wt_seen);
    logic found;
    found = 1'b0;
    data = '0;
    rd_seen = 1'b0;
    wt_seen = 1'b0;
    @(posedge clk);
    ld_valid <= ld;
    st_valid <= st;
    addr <= a;
    size <= sz;
    ld_unsigned <= uns;
    st_data <= d;
    for (lat = 0; lat < WAIT_LIMIT; lat++) begin
      @(negedge clk);
      if (rd_done || wt_done) begin
        found = 1'b1;
        rd_seen = rd_done;
        wt_seen = wt_done;
        data = ld_data;
        break;
      end
      @(posedge clk);
      ld_valid <= 1'b0;  // Strobes last one cycle
      st_valid <= 1'b0;
    end
    if (!found) begin
      $display("Timeout: no done strobe within %0d cycles of the request at %0t", WAIT_LIMIT,
               $time);
      errors++;
    end
  endtask

  task automatic do_store(input logic [31:0] a, input mem_size_e sz, input logic [31:0] d);
    logic [31:0] got;
    int lat;
    logic rs, ws;
    access(1'b0, 1'b1, a, sz, 1'b0, d, got, lat, rs, ws);
    check_value(ws, 1, "store wt_done");
    check_value(rs, 0, "store raised rd_done");
    check_value(lat, DELAY, "store latency");
    ref_store(a, sz, d);
  endtask

  task automatic do_load(input logic [31:0] a, input mem_size_e sz, input logic uns);
    logic [31:0] got, exp;
    int lat;
    logic rs, ws;
    exp = ref_load(a, sz, uns);
    access(1'b1, 1'b0, a, sz, uns, 32'h0, got, lat, rs, ws);
    check_value(rs, 1, "load rd_done");
    check_value(ws, 0, "load raised wt_done");
    check_value(lat, DELAY, "load latency");
    check_value(got, exp, $sformatf("load data at %h size %s uns %0d", a, sz.name(), uns));
  endtask

  task automatic test_reset_state();
    int err0;
    err0 = errors;
    repeat (6) begin
      @(negedge clk);
      check_value({rd_done, wt_done}, 0, "done strobe after reset");
      check_value(ld_data, 0, "ld_data after reset");
    end
    finish_test("reset_state", err0);
  endtask

  // Words 0 to 15 get random data, random upper address bits test the wrap
  task automatic test_word_rw();
    int err0;
    err0 = errors;
    for (int i = 0; i < 16; i++) do_store((rand_bits(32) & 32'hFFFF_FC00) | (i << 2),
                                          SIZE_WORD, rand_bits(32));
    for (int i = 0; i < 16; i++) do_load((rand_bits(32) & 32'hFFFF_FC00) | (i << 2),
                                         SIZE_WORD, 1'b0);
    finish_test("word_write_read", err0);
  endtask

  task automatic test_partial_store();
    int err0;
    logic [31:0] a;
    mem_size_e sz;
    err0 = errors;
    repeat (12) begin
      a = rand_bits(4) << 2;
      sz = rand_bits(1) ? SIZE_HALF : SIZE_BYTE;
      do_store(a | rand_bits(2), sz, rand_bits(32));
      do_load(a, SIZE_WORD, 1'b0);
    end
    finish_test("byte_half_store", err0);
  endtask

  task automatic test_sub_loads();
    int err0;
    logic [31:0] a;
    err0 = errors;
    for (int w = 0; w < 2; w++) begin
      a = rand_bits(4) << 2;
      do_store(a, SIZE_WORD, (w == 0) ? 32'h7F80_FF01 : rand_bits(32));  // Both sign cases
      for (int ofs = 0; ofs < 4; ofs++) begin
        for (int uns = 0; uns < 2; uns++) begin
          do_load(a + ofs, SIZE_BYTE, uns[0]);
          do_load(a + ofs, SIZE_HALF, uns[0]);
        end
      end
    end
    finish_test("byte_half_load", err0);
  endtask

  // Four stores then four loads in reverse order, one per cycle
  task automatic test_pipelined();
    int err0, base, j;
    logic [31:0] a [8];
    logic [31:0] d [8];
    logic [31:0] exp [8];
    err0 = errors;
    base = rand_bits(3);
    for (int i = 0; i < 4; i++) begin
      a[i] = (base + i) << 2;
      d[i] = rand_bits(32);
      ref_store(a[i], SIZE_WORD, d[i]);
    end
    for (int i = 4; i < 8; i++) begin
      a[i] = a[7-i];
      d[i] = '0;
      exp[i] = ref_load(a[i], SIZE_WORD, 1'b0);
    end
    for (int cyc = 0; cyc < 8 + DELAY + 2; cyc++) begin
      @(posedge clk);
      ld_valid <= (cyc >= 4 && cyc < 8);
      st_valid <= (cyc < 4);
      if (cyc < 8) begin
        addr <= a[cyc];
        st_data <= d[cyc];
        size <= SIZE_WORD;
        ld_unsigned <= 1'b0;
      end
      @(negedge clk);
      j = cyc - DELAY;  // Request whose response is due now
      check_value(wt_done, (j >= 0 && j < 4), $sformatf("pipelined wt_done in cycle %0d", cyc));
      check_value(rd_done, (j >= 4 && j < 8), $sformatf("pipelined rd_done in cycle %0d", cyc));
      if (j >= 4 && j < 8) check_value(ld_data, exp[j], $sformatf("pipelined load %0d", j));
    end
    finish_test("pipelined", err0);
  endtask

  task automatic test_collision();
    int err0, lat;
    logic [31:0] a, old, got;
    logic rs, ws;
    err0 = errors;
    a = rand_bits(4) << 2;
    old = ref_load(a, SIZE_WORD, 1'b0);
    access(1'b1, 1'b1, a, SIZE_WORD, 1'b0, ~old, got, lat, rs, ws);
    check_value(rs, 1, "collision rd_done");
    check_value(ws, 0, "collision wt_done");
    check_value(lat, DELAY, "collision latency");
    check_value(got, old, "collision read data");
    repeat (3) begin
      @(negedge clk);
      check_value(wt_done, 0, "late wt_done after collision");
    end
    do_load(a, SIZE_WORD, 1'b0);  // Dropped write left the word alone
    finish_test("collision", err0);
  endtask

  initial begin
    lfsr_state = 16'd99;
    rst = 1'b1;
    ld_valid = 1'b0;
    st_valid = 1'b0;
    addr = '0;
    size = SIZE_WORD;
    ld_unsigned = 1'b0;
    st_data = '0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    test_reset_state();
    test_word_rw();
    test_partial_store();
    test_sub_loads();
    test_pipelined();
    test_collision();
    $display("Summary: %0d checks, %0d errors, %0d of %0d tests failed", checks, errors,
             tests_failed, tests_run);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: logic/mem_subsys_top.sv
// Data-memory subsystem top, joining aligner, delay chain, storage and load extraction
`timescale 1ns/10ps
`include "mem_params.svh"

module mem_subsys_top import mem_pkg::*; (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       ld_valid,
  input  logic                       st_valid,
  input  logic [`MEM_DATA_WIDTH-1:0] addr,
  input  mem_size_e                  size,
  input  logic                       ld_unsigned,
  input  logic [`MEM_DATA_WIDTH-1:0] st_data,
  output logic [`MEM_DATA_WIDTH-1:0] ld_data,
  output logic                       rd_done,
  output logic                       wt_done
);

  mem_req_if core_req ();  // Aligned request as issued
  mem_req_if dly_req ();   // Same request after the latency

  logic [`MEM_DATA_WIDTH-1:0] rdata;

  store_align u_align (
    .ld_valid    (ld_valid),
    .st_valid    (st_valid),
    .addr        (addr),
    .size        (size),
    .ld_unsigned (ld_unsigned),
    .st_data     (st_data),
    .req         (core_req.src)
  );

  req_delay_line #(
    .DELAY_CYCLES (`MEM_DELAY_CYCLES)
  ) u_delay (
    .clk (clk),
    .rst (rst),
    .in  (core_req.dst),
    .out (dly_req.src)
  );

  sram_array #(
    .DEPTH (`MEM_DEPTH_WORDS)
  ) u_sram (
    .clk     (clk),
    .rst     (rst),
    .req     (dly_req.dst),
    .rdata   (rdata),
    .rd_done (rd_done),
    .wt_done (wt_done)
  );

  load_extract u_extract (
    .rdata   (rdata),
    .rd_done (rd_done),
    .req     (dly_req.dst),
    .ld_data (ld_data)
  );

endmodule

// File: logic/load_extract.sv
// Picks the addressed byte or half out of a read word and zero- or sign-extends it for the core
`timescale 1ns/10ps
`include "mem_params.svh"

module load_extract import mem_pkg::*; (
  input  logic [`MEM_DATA_WIDTH-1:0] rdata,
  input  logic                       rd_done,
  mem_req_if.dst                     req,
  output logic [`MEM_DATA_WIDTH-1:0] ld_data
);

  logic [`MEM_DATA_WIDTH-1:0] shifted;
  logic                       byte_fill;
  logic                       half_fill;

  // Move the addressed lane down to bit 0
  assign shifted = rdata >> {req.offset, 3'b000};

  // Extension bit is the field's top bit unless the load is unsigned
  assign byte_fill = !req.is_unsigned && shifted[7];
  assign half_fill = !req.is_unsigned && shifted[15];

  always_comb begin
    ld_data = '0;  // Quiet when no read completes
    if (rd_done) begin
      case (req.size)
        SIZE_BYTE: ld_data = {{(`MEM_DATA_WIDTH-8){byte_fill}}, shifted[7:0]};
        SIZE_HALF: ld_data = {{(`MEM_DATA_WIDTH-16){half_fill}}, shifted[15:0]};
        default:   ld_data = rdata;  // Word loads pass through
      endcase
    end
  end

endmodule

// File: logic/sram_array.sv
// Byte-masked word storage serving delayed requests, with read priority and done strobes
`timescale 1ns/10ps
`include "mem_params.svh"

module sram_array import mem_pkg::*; #(
  parameter int DEPTH = `MEM_DEPTH_WORDS
) (
  input  logic                       clk,
  input  logic                       rst,
  mem_req_if.dst                     req,
  output logic [`MEM_DATA_WIDTH-1:0] rdata,
  output logic                       rd_done,
  output logic                       wt_done
);

  localparam int IDX_BITS = $clog2(DEPTH);

  logic [`MEM_DATA_WIDTH-1:0] mem [DEPTH];  // Contents undefined until written
  logic [IDX_BITS-1:0]        idx;
  logic                       wr_en;

  // Upper word-address bits wrap onto the array
  assign idx = req.word_addr[IDX_BITS-1:0];

  // A read in the same cycle wins and the write is dropped
  assign wr_en = req.wt_valid && !req.rd_valid;

  // Byte lanes update at the next edge
  always_ff @(posedge clk) begin
    if (wr_en && !rst) begin  // Nothing lands while reset is held
      for (int lane = 0; lane < MEM_LANES; lane++) begin
        if (req.wmask[lane]) begin
          mem[idx][lane*8 +: 8] <= req.wdata[lane*8 +: 8];
        end
      end
    end
  end

  // Read path is combinational off the delayed request
  assign rdata   = req.rd_valid ? mem[idx] : '0;
  assign rd_done = req.rd_valid;
  assign wt_done = wr_en;  // No strobe for a lost write

endmodule

// File: logic/req_delay_line.sv
// Register chain that holds each aligned request for a fixed number of cycles to model slow memory
`timescale 1ns/10ps
`include "mem_params.svh"

module req_delay_line import mem_pkg::*; #(
  parameter int DELAY_CYCLES = `MEM_DELAY_CYCLES
) (
  input  logic   clk,
  input  logic   rst,
  mem_req_if.dst in,
  mem_req_if.src out
);

  // One entry per stage, index 0 is the youngest
  logic                       rd_q       [DELAY_CYCLES];
  logic                       wt_q       [DELAY_CYCLES];
  logic [MEM_WADDR_BITS-1:0]  waddr_q    [DELAY_CYCLES];
  logic [`MEM_DATA_WIDTH-1:0] wdata_q    [DELAY_CYCLES];
  logic [MEM_LANES-1:0]       wmask_q    [DELAY_CYCLES];
  logic [MEM_OFS_BITS-1:0]    offset_q   [DELAY_CYCLES];
  mem_size_e                  size_q     [DELAY_CYCLES];
  logic                       unsigned_q [DELAY_CYCLES];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < DELAY_CYCLES; i++) begin
        rd_q[i]       <= 1'b0;
        wt_q[i]       <= 1'b0;
        waddr_q[i]    <= '0;
        wdata_q[i]    <= '0;
        wmask_q[i]    <= '0;
        offset_q[i]   <= '0;
        size_q[i]     <= SIZE_BYTE;
        unsigned_q[i] <= 1'b0;
      end
    end else begin
      rd_q[0]       <= in.rd_valid;
      wt_q[0]       <= in.wt_valid;
      waddr_q[0]    <= in.word_addr;
      wdata_q[0]    <= in.wdata;
      wmask_q[0]    <= in.wmask;
      offset_q[0]   <= in.offset;
      size_q[0]     <= in.size;
      unsigned_q[0] <= in.is_unsigned;
      // Loop is empty for a single stage
      for (int i = 1; i < DELAY_CYCLES; i++) begin
        rd_q[i]       <= rd_q[i-1];
        wt_q[i]       <= wt_q[i-1];
        waddr_q[i]    <= waddr_q[i-1];
        wdata_q[i]    <= wdata_q[i-1];
        wmask_q[i]    <= wmask_q[i-1];
        offset_q[i]   <= offset_q[i-1];
        size_q[i]     <= size_q[i-1];
        unsigned_q[i] <= unsigned_q[i-1];
      end
    end
  end

  // Oldest stage feeds the storage side
  assign out.rd_valid    = rd_q[DELAY_CYCLES-1];
  assign out.wt_valid    = wt_q[DELAY_CYCLES-1];
  assign out.word_addr   = waddr_q[DELAY_CYCLES-1];
  assign out.wdata       = wdata_q[DELAY_CYCLES-1];
  assign out.wmask       = wmask_q[DELAY_CYCLES-1];
  assign out.offset      = offset_q[DELAY_CYCLES-1];
  assign out.size        = size_q[DELAY_CYCLES-1];
  assign out.is_unsigned = unsigned_q[DELAY_CYCLES-1];

endmodule

// File: logic/store_align.sv
// Converts a core-side load/store into an aligned request with lane mask and lane-placed data
`timescale 1ns/10ps
`include "mem_params.svh"

module store_align import mem_pkg::*; (
  input  logic                       ld_valid,
  input  logic                       st_valid,
  input  logic [`MEM_DATA_WIDTH-1:0] addr,
  input  mem_size_e                  size,
  input  logic                       ld_unsigned,
  input  logic [`MEM_DATA_WIDTH-1:0] st_data,
  mem_req_if.src                     req
);

  logic [MEM_OFS_BITS-1:0]    offset;
  logic [MEM_LANES-1:0]       lane_mask;
  logic [`MEM_DATA_WIDTH-1:0] lane_data;

  // Misaligned low bits are dropped according to the access size
  always_comb begin
    case (size)
      SIZE_BYTE: offset = addr[MEM_OFS_BITS-1:0];
      SIZE_HALF: offset = {addr[MEM_OFS_BITS-1:1], 1'b0};
      default:   offset = '0;  // Word, and the unused encoding
    endcase
  end

  // Lane mask follows size, then slides up to the offset
  always_comb begin
    case (size)
      SIZE_BYTE: lane_mask = {{(MEM_LANES-1){1'b0}}, 1'b1} << offset;
      SIZE_HALF: lane_mask = {{(MEM_LANES-2){1'b0}}, 2'b11} << offset;
      default:   lane_mask = '1;
    endcase
  end

  // Copy the low byte or half into every slot, the mask picks the live lanes
  always_comb begin
    case (size)
      SIZE_BYTE: lane_data = {MEM_LANES{st_data[7:0]}};
      SIZE_HALF: lane_data = {(MEM_LANES/2){st_data[15:0]}};
      default:   lane_data = st_data;
    endcase
  end

  assign req.rd_valid    = ld_valid;
  assign req.wt_valid    = st_valid;
  assign req.word_addr   = addr[`MEM_DATA_WIDTH-1:MEM_OFS_BITS];
  assign req.wdata       = lane_data;
  assign req.wmask       = lane_mask;
  assign req.offset      = offset;
  assign req.size        = size;
  assign req.is_unsigned = ld_unsigned;  // Only meaningful for loads

endmodule

// File: logic/mem_req_if.sv
// Aligned memory request bundle, used between the aligner, the delay chain and the storage side
`timescale 1ns/10ps
`include "mem_params.svh"

interface mem_req_if import mem_pkg::*; ();

  logic                      rd_valid;     // Load strobe, one cycle per request
  logic                      wt_valid;     // Store strobe, one cycle per request
  logic [MEM_WADDR_BITS-1:0] word_addr;    // Address with byte offset removed
  logic [`MEM_DATA_WIDTH-1:0] wdata;       // Store data already placed in its lanes
  logic [MEM_LANES-1:0]      wmask;        // One bit per byte lane to update
  logic [MEM_OFS_BITS-1:0]   offset;       // Byte offset, kept for the load path
  mem_size_e                 size;
  logic                      is_unsigned;  // Zero-extend loads when set

  // Driving side
  modport src (
    output rd_valid,
    output wt_valid,
    output word_addr,
    output wdata,
    output wmask,
    output offset,
    output size,
    output is_unsigned
  );

  // Receiving side
  modport dst (
    input rd_valid,
    input wt_valid,
    input word_addr,
    input wdata,
    input wmask,
    input offset,
    input size,
    input is_unsigned
  );

endinterface

// File: logic/mem_pkg.sv
// Shared access-size type and lane constants, imported by the RTL blocks and the testbench
`include "mem_params.svh"

package mem_pkg;

  // Byte lanes per data word, also the write mask width
  localparam int MEM_LANES = `MEM_DATA_WIDTH / 8;
  localparam int MEM_OFS_BITS = $clog2(MEM_LANES);  // Byte offset bits inside a word
  localparam int MEM_WADDR_BITS = `MEM_DATA_WIDTH - MEM_OFS_BITS;  // Word index bits

  // Access size as carried with each request
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_WORD = 2'b10
  } mem_size_e;

endpackage

// File: logic/mem_params.svh
// Sizing macros for the data-memory subsystem, included by the package, interface and RTL
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// Data word and address width in bits
`define MEM_DATA_WIDTH 32

// Words held by the storage array, upper address bits wrap
`define MEM_DEPTH_WORDS 256

// Request latency through the delay chain, must be 1 or more
`define MEM_DELAY_CYCLES 3

`endif
